//--- flist.f
logic/emu_cfg_pkg.sv
logic/emu_ctrl_pkg.sv
logic/delay_table.sv
logic/local_ctrl_fsm.sv
logic/sample_ring.sv
logic/tap_addr_gen.sv
logic/controller_integrated.sv
dv/tb_clock_gen.sv
dv/tb_controller_integrated.sv

//--- dv/tb_controller_integrated.sv
`timescale 1ns/1ps

module tb_controller_integrated;

	localparam int hw_lat = 5;           // hardware latency in samples
	localparam int scen_len = 20;        // accepted samples per period
	localparam int boot_cycles = 40;     // reset, boot, ready and start
	localparam int run_cycles = 24 + 80 + 120 + 70 + 64 + 64;
	localparam int timeout_cycles = boot_cycles + run_cycles + 200;
	localparam int fill_max = emu_cfg_pkg::ring_depth - 1;

	logic CLK;
	logic rst_n;
	logic boot_up, input_valid, scen_valid, table_update, start, data_valid;
	emu_cfg_pkg::delay_t delay_matrix_element;
	emu_cfg_pkg::obj_id_t obj_id_element;
	emu_cfg_pkg::delay_t hardware_latency;
	emu_cfg_pkg::scen_len_t scenario_len;
	emu_cfg_pkg::sample_t data_in;
	emu_cfg_pkg::sample_t final_out_0, final_out_1, final_out_2, final_out_3;
	logic run_active, scen_boundary;

	// reference model state
	emu_ctrl_pkg::ctrl_phase_t m_phase;
	emu_cfg_pkg::sample_t hist [$];      // every accepted sample, oldest first
	emu_cfg_pkg::sample_t exp_out [emu_cfg_pkg::n_obj];
	emu_cfg_pkg::delay_t m_active [emu_cfg_pkg::n_obj];
	emu_cfg_pkg::delay_t m_shadow [emu_cfg_pkg::n_obj];
	logic [emu_cfg_pkg::n_obj-1:0] m_loaded;
	logic m_pending, m_run, exp_bnd;
	int m_cnt;

	int errors = 0;
	int failed_tests = 0;
	int test_num = 0;
	int cycles = 0;
	int seed = 37;
	int ramp = 0;                        // ramp position, advances on valid only

	tb_clock_gen i_clk (.CLK(CLK), .rst_n(rst_n));

	controller_integrated i_dut (.*);

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic int tap_offset(emu_cfg_pkg::delay_t dly, emu_cfg_pkg::delay_t lat);
		int ofs;
		if (dly <= lat) return emu_ctrl_pkg::min_tap_offset;   // floor for short paths
		ofs = (int'(dly) - int'(lat)) % emu_cfg_pkg::ring_depth;
		return (ofs < emu_ctrl_pkg::min_tap_offset) ? emu_ctrl_pkg::min_tap_offset : ofs;
	endfunction

	assign exp_bnd = m_run && data_valid && (m_cnt == int'(scenario_len) - 1);

	always @(posedge CLK) begin : ref_model
		int fill_now;
		int ofs;
		logic accept;
		logic commit;
		if (!rst_n) begin
			m_phase = emu_ctrl_pkg::phase_idle;
			m_run = 1'b0;
			m_cnt = 0;
			m_loaded = '0;
			m_pending = 1'b0;
			hist.delete();
			for (int k = 0; k < emu_cfg_pkg::n_obj; k++) exp_out[k] = '0;
		end else begin
			accept = m_run && data_valid;
			commit = exp_bnd && m_pending;
			if (accept) begin
				fill_now = (hist.size() > fill_max) ? fill_max : hist.size();   // before write
				for (int k = 0; k < emu_cfg_pkg::n_obj; k++) begin
					ofs = tap_offset(m_active[k], hardware_latency);
					if (!m_loaded[k] || (fill_now < ofs)) exp_out[k] = '0;
					else exp_out[k] = hist[hist.size() - ofs];
				end
				hist.push_back(data_in);
				m_cnt = exp_bnd ? 0 : m_cnt + 1;   // wrap on the boundary
			end
			// tables use the phase held before this edge
			if (commit) begin
				for (int k = 0; k < emu_cfg_pkg::n_obj; k++) m_active[k] = m_shadow[k];
			end else if (input_valid && (m_phase == emu_ctrl_pkg::phase_boot)) begin
				m_active[obj_id_element] = delay_matrix_element;
			end
			if ((input_valid && (m_phase == emu_ctrl_pkg::phase_boot)) ||
				(scen_valid && (m_phase == emu_ctrl_pkg::phase_run))) begin
				m_shadow[obj_id_element] = delay_matrix_element;
			end
			if (input_valid && (m_phase == emu_ctrl_pkg::phase_boot)) m_loaded[obj_id_element] = 1'b1;
			m_pending = table_update ? 1'b1 : (commit ? 1'b0 : m_pending);
			case (m_phase)
				emu_ctrl_pkg::phase_idle:  if (boot_up) m_phase = emu_ctrl_pkg::phase_boot;
				emu_ctrl_pkg::phase_boot:  if (!boot_up) m_phase = emu_ctrl_pkg::phase_ready;
				emu_ctrl_pkg::phase_ready: if (start) m_phase = emu_ctrl_pkg::phase_run;
				default: m_phase = m_phase;
			endcase
			m_run = (m_phase == emu_ctrl_pkg::phase_run);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic value_error(string what, logic [31:0] got, logic [31:0] exp);
		$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		errors++;
	endtask

	a_out_0: assert property (@(posedge CLK) disable iff (!rst_n) final_out_0 == exp_out[0])
		else value_error("final_out_0", $sampled(final_out_0), $sampled(exp_out[0]));
	a_out_1: assert property (@(posedge CLK) disable iff (!rst_n) final_out_1 == exp_out[1])
		else value_error("final_out_1", $sampled(final_out_1), $sampled(exp_out[1]));
	a_out_2: assert property (@(posedge CLK) disable iff (!rst_n) final_out_2 == exp_out[2])
		else value_error("final_out_2", $sampled(final_out_2), $sampled(exp_out[2]));
	a_out_3: assert property (@(posedge CLK) disable iff (!rst_n) final_out_3 == exp_out[3])
		else value_error("final_out_3", $sampled(final_out_3), $sampled(exp_out[3]));
	a_run: assert property (@(posedge CLK) disable iff (!rst_n) run_active == m_run)
		else value_error("run_active", $sampled(run_active), $sampled(m_run));
	a_bnd: assert property (@(posedge CLK) disable iff (!rst_n) scen_boundary == exp_bnd)
		else value_error("scen_boundary", $sampled(scen_boundary), $sampled(exp_bnd));

	// a gap cycle freezes every tap
	a_hold: assert property (@(posedge CLK) disable iff (!rst_n) !data_valid |=>
		$stable({final_out_0, final_out_1, final_out_2, final_out_3}))
		else begin
			$display("[ERROR] %0t ns: a final output changed after a data_valid gap", $time);
			errors++;
		end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout: stimulus did not finish within %0d cycles", timeout_cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	// one cycle, strobes cleared, sample or gap word on data_in
	task automatic drive_cycle(input logic dv);
		@(posedge CLK);
		#1;
		input_valid = 1'b0;
		scen_valid = 1'b0;
		table_update = 1'b0;
		start = 1'b0;
		data_valid = dv;
		data_in = dv ? {ramp[15:0], ~ramp[15:0]} : 32'hdead_beef;
		if (dv) ramp++;
	endtask

	task automatic table_write(input logic boot, input int obj, input int dly);
		drive_cycle(!boot);   // updates during run ride along with a sample
		input_valid = boot;
		scen_valid = !boot;
		obj_id_element = emu_cfg_pkg::obj_id_t'(obj);
		delay_matrix_element = emu_cfg_pkg::delay_t'(dly);
	endtask

	task automatic run_samples(input int n, input logic gaps);
		int r;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			drive_cycle(!gaps || (r[1:0] != 2'b00));   // about one gap in four
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		test_num++;
		if (errors == err_before) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: %0d errors", test_num, name, errors - err_before);
			failed_tests++;
		end
	endtask

	initial begin : main
		int e;
		boot_up = 1'b0;
		input_valid = 1'b0;
		scen_valid = 1'b0;
		table_update = 1'b0;
		start = 1'b0;
		data_valid = 1'b0;
		data_in = '0;
		obj_id_element = '0;
		delay_matrix_element = '0;
		hardware_latency = emu_cfg_pkg::delay_t'(hw_lat);
		scenario_len = emu_cfg_pkg::scen_len_t'(scen_len);
		wait (rst_n === 1'b1);

		// idle, boot, ready, start
		e = errors;
		run_samples(5, 1'b0);             // samples before run are ignored
		drive_cycle(1'b0);
		boot_up = 1'b1;
		drive_cycle(1'b0);
		table_write(1'b1, 0, hw_lat + 3);   // offset 3
		table_write(1'b1, 1, hw_lat + 17);  // offset 17
		table_write(1'b1, 2, hw_lat - 1);   // at or under latency, offset 1
		drive_cycle(1'b0);
		boot_up = 1'b0;
		run_samples(4, 1'b0);
		start = 1'b1;
		do drive_cycle(1'b0); while (!run_active);
		report_test("reset_boot_start", e);

		e = errors;
		run_samples(24, 1'b0);            // history shorter than offsets first
		report_test("fill_and_clamp", e);
		e = errors;
		run_samples(80, 1'b0);
		report_test("loaded_taps", e);
		e = errors;
		run_samples(120, 1'b1);
		report_test("valid_gaps", e);
		e = errors;
		run_samples(70, 1'b1);
		report_test("period_boundary", e);

		// shadow writes then commit, switch lands on next boundary
		e = errors;
		table_write(1'b0, 0, hw_lat + 40);
		table_write(1'b0, 1, hw_lat + 9);
		table_write(1'b0, 3, hw_lat + 2);   // obj 3 was never boot-loaded
		drive_cycle(1'b1);
		table_update = 1'b1;
		run_samples(60, 1'b1);
		report_test("commit_at_boundary", e);

		e = errors;
		table_write(1'b0, 0, hw_lat + 60);  // no commit request follows
		table_write(1'b0, 2, hw_lat + 30);
		run_samples(60, 1'b1);
		drive_cycle(1'b0);
		drive_cycle(1'b0);
		report_test("no_commit", e);

		$display("tests %0d, failed %0d, errors %0d", test_num, failed_tests, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLK,
	output logic rst_n
);

	localparam int reset_cycles = 10;

	// 4 ns period
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// release just after an edge, like the rest of the stimulus
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge CLK);
		#1 rst_n = 1'b1;
	end

endmodule

//--- logic/controller_integrated.sv
`timescale 1ns/1ps

module controller_integrated (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  logic                     boot_up,
	input  logic                     input_valid,
	input  logic                     scen_valid,
	input  logic                     table_update,
	input  logic                     start,
	input  emu_cfg_pkg::delay_t      delay_matrix_element,
	input  emu_cfg_pkg::obj_id_t     obj_id_element,
	input  emu_cfg_pkg::delay_t      hardware_latency,
	input  emu_cfg_pkg::scen_len_t   scenario_len,
	input  logic                     data_valid,
	input  emu_cfg_pkg::sample_t     data_in,
	output emu_cfg_pkg::sample_t     final_out_0,
	output emu_cfg_pkg::sample_t     final_out_1,
	output emu_cfg_pkg::sample_t     final_out_2,
	output emu_cfg_pkg::sample_t     final_out_3,
	output logic                     run_active,
	output logic                     scen_boundary
);

	emu_ctrl_pkg::ctrl_phase_t phase;

	// active table view
	emu_cfg_pkg::delay_t active_delay_0;
	emu_cfg_pkg::delay_t active_delay_1;
	emu_cfg_pkg::delay_t active_delay_2;
	emu_cfg_pkg::delay_t active_delay_3;
	logic [emu_cfg_pkg::n_obj-1:0] active_loaded;

	// ring addressing
	emu_cfg_pkg::sample_addr_t wr_ptr;
	emu_cfg_pkg::sample_addr_t rd_addr_0;
	emu_cfg_pkg::sample_addr_t rd_addr_1;
	emu_cfg_pkg::sample_addr_t rd_addr_2;
	emu_cfg_pkg::sample_addr_t rd_addr_3;
	emu_cfg_pkg::sample_addr_t tap_offset_0;
	emu_cfg_pkg::sample_addr_t tap_offset_1;
	emu_cfg_pkg::sample_addr_t tap_offset_2;
	emu_cfg_pkg::sample_addr_t tap_offset_3;

	////////////////////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////////////////////

	local_ctrl_fsm i_fsm (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.boot_up       (boot_up),
		.start         (start),
		.data_valid    (data_valid),
		.scenario_len  (scenario_len),
		.phase         (phase),
		.run_active    (run_active),
		.scen_boundary (scen_boundary)
	);

	delay_table i_table (
		.CLK                  (CLK),
		.rst_n                (rst_n),
		.phase                (phase),
		.input_valid          (input_valid),
		.scen_valid           (scen_valid),
		.table_update         (table_update),
		.scen_boundary        (scen_boundary),   // commit point
		.delay_matrix_element (delay_matrix_element),
		.obj_id_element       (obj_id_element),
		.active_delay_0       (active_delay_0),
		.active_delay_1       (active_delay_1),
		.active_delay_2       (active_delay_2),
		.active_delay_3       (active_delay_3),
		.active_loaded        (active_loaded)
	);

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	tap_addr_gen i_addr (
		.wr_ptr           (wr_ptr),
		.hardware_latency (hardware_latency),
		.active_delay_0   (active_delay_0),
		.active_delay_1   (active_delay_1),
		.active_delay_2   (active_delay_2),
		.active_delay_3   (active_delay_3),
		.rd_addr_0        (rd_addr_0),
		.rd_addr_1        (rd_addr_1),
		.rd_addr_2        (rd_addr_2),
		.rd_addr_3        (rd_addr_3),
		.tap_offset_0     (tap_offset_0),
		.tap_offset_1     (tap_offset_1),
		.tap_offset_2     (tap_offset_2),
		.tap_offset_3     (tap_offset_3)
	);

	sample_ring i_ring (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.run_active    (run_active),
		.data_valid    (data_valid),
		.data_in       (data_in),
		.rd_addr_0     (rd_addr_0),
		.rd_addr_1     (rd_addr_1),
		.rd_addr_2     (rd_addr_2),
		.rd_addr_3     (rd_addr_3),
		.tap_offset_0  (tap_offset_0),
		.tap_offset_1  (tap_offset_1),
		.tap_offset_2  (tap_offset_2),
		.tap_offset_3  (tap_offset_3),
		.active_loaded (active_loaded),
		.wr_ptr        (wr_ptr),          // back to address gen
		.final_out_0   (final_out_0),
		.final_out_1   (final_out_1),
		.final_out_2   (final_out_2),
		.final_out_3   (final_out_3)
	);

endmodule

//--- logic/tap_addr_gen.sv
`timescale 1ns/1ps

module tap_addr_gen (
	input  emu_cfg_pkg::sample_addr_t wr_ptr,
	input  emu_cfg_pkg::delay_t       hardware_latency,
	input  emu_cfg_pkg::delay_t       active_delay_0,
	input  emu_cfg_pkg::delay_t       active_delay_1,
	input  emu_cfg_pkg::delay_t       active_delay_2,
	input  emu_cfg_pkg::delay_t       active_delay_3,
	output emu_cfg_pkg::sample_addr_t rd_addr_0,
	output emu_cfg_pkg::sample_addr_t rd_addr_1,
	output emu_cfg_pkg::sample_addr_t rd_addr_2,
	output emu_cfg_pkg::sample_addr_t rd_addr_3,
	output emu_cfg_pkg::sample_addr_t tap_offset_0,
	output emu_cfg_pkg::sample_addr_t tap_offset_1,
	output emu_cfg_pkg::sample_addr_t tap_offset_2,
	output emu_cfg_pkg::sample_addr_t tap_offset_3
);

	////////////////////////////////////////////////////////////////////////////
	// offset = delay - latency, truncated and clamped
	////////////////////////////////////////////////////////////////////////////

	function automatic emu_cfg_pkg::sample_addr_t calc_offset(
		input emu_cfg_pkg::delay_t dly,
		input emu_cfg_pkg::delay_t lat
	);
		emu_cfg_pkg::delay_t diff;
		emu_cfg_pkg::sample_addr_t ofs;
		emu_cfg_pkg::sample_addr_t ofs_min;

		ofs_min = emu_cfg_pkg::sample_addr_t'(emu_ctrl_pkg::min_tap_offset);
		diff = dly - lat;
		ofs = emu_cfg_pkg::sample_addr_t'(diff);   // keep ring-sized low bits

		// delay at or under latency, or a multiple of 256, falls to the floor
		if ((dly <= lat) || (ofs < ofs_min)) begin
			ofs = ofs_min;
		end
		return ofs;
	endfunction

	// per-object offsets
	assign tap_offset_0 = calc_offset(active_delay_0, hardware_latency);
	assign tap_offset_1 = calc_offset(active_delay_1, hardware_latency);
	assign tap_offset_2 = calc_offset(active_delay_2, hardware_latency);
	assign tap_offset_3 = calc_offset(active_delay_3, hardware_latency);

	////////////////////////////////////////////////////////////////////////////
	// read addresses behind the write pointer
	////////////////////////////////////////////////////////////////////////////

	assign rd_addr_0 = wr_ptr - tap_offset_0;   // modulo 256
	assign rd_addr_1 = wr_ptr - tap_offset_1;
	assign rd_addr_2 = wr_ptr - tap_offset_2;
	assign rd_addr_3 = wr_ptr - tap_offset_3;

endmodule

//--- logic/sample_ring.sv
`timescale 1ns/1ps

module sample_ring (
	input  logic                          CLK,
	input  logic                          rst_n,
	input  logic                          run_active,
	input  logic                          data_valid,
	input  emu_cfg_pkg::sample_t          data_in,
	input  emu_cfg_pkg::sample_addr_t     rd_addr_0,
	input  emu_cfg_pkg::sample_addr_t     rd_addr_1,
	input  emu_cfg_pkg::sample_addr_t     rd_addr_2,
	input  emu_cfg_pkg::sample_addr_t     rd_addr_3,
	input  emu_cfg_pkg::sample_addr_t     tap_offset_0,
	input  emu_cfg_pkg::sample_addr_t     tap_offset_1,
	input  emu_cfg_pkg::sample_addr_t     tap_offset_2,
	input  emu_cfg_pkg::sample_addr_t     tap_offset_3,
	input  logic [emu_cfg_pkg::n_obj-1:0] active_loaded,
	output emu_cfg_pkg::sample_addr_t     wr_ptr,
	output emu_cfg_pkg::sample_t          final_out_0,
	output emu_cfg_pkg::sample_t          final_out_1,
	output emu_cfg_pkg::sample_t          final_out_2,
	output emu_cfg_pkg::sample_t          final_out_3
);

	emu_cfg_pkg::sample_t mem [emu_cfg_pkg::ring_depth];   // circular sample store

	emu_cfg_pkg::sample_addr_t fill;   // words written, saturates at all ones
	emu_cfg_pkg::sample_addr_t rd_addr [emu_cfg_pkg::n_obj];
	emu_cfg_pkg::sample_addr_t tap_ofs [emu_cfg_pkg::n_obj];
	emu_cfg_pkg::sample_t out_q [emu_cfg_pkg::n_obj];
	logic accept;

	assign accept = run_active && data_valid;   // only back-pressure is data_valid

	// gather the loose tap ports
	assign rd_addr[0] = rd_addr_0;
	assign rd_addr[1] = rd_addr_1;
	assign rd_addr[2] = rd_addr_2;
	assign rd_addr[3] = rd_addr_3;
	assign tap_ofs[0] = tap_offset_0;
	assign tap_ofs[1] = tap_offset_1;
	assign tap_ofs[2] = tap_offset_2;
	assign tap_ofs[3] = tap_offset_3;

	////////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (accept) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			fill   <= '0;
		end else if (accept) begin
			wr_ptr <= wr_ptr + emu_cfg_pkg::sample_addr_t'(1);   // wraps at 256
			if (fill != '1) begin
				fill <= fill + emu_cfg_pkg::sample_addr_t'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// registered read ports
	////////////////////////////////////////////////////////////////////////////

	// offset >= 1 so reads never hit the word being written
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int k = 0; k < emu_cfg_pkg::n_obj; k++) begin
				out_q[k] <= '0;
			end
		end else if (accept) begin
			for (int k = 0; k < emu_cfg_pkg::n_obj; k++) begin
				if (!active_loaded[k] || (fill < tap_ofs[k])) begin
					out_q[k] <= '0;   // no tap yet, or history too short
				end else begin
					out_q[k] <= mem[rd_addr[k]];
				end
			end
		end
	end

	assign final_out_0 = out_q[0];
	assign final_out_1 = out_q[1];
	assign final_out_2 = out_q[2];
	assign final_out_3 = out_q[3];

endmodule

//--- logic/local_ctrl_fsm.sv
`timescale 1ns/1ps

module local_ctrl_fsm (
	input  logic                      CLK,
	input  logic                      rst_n,
	input  logic                      boot_up,       // level, boot window
	input  logic                      start,         // pulse, begins run
	input  logic                      data_valid,
	input  emu_cfg_pkg::scen_len_t    scenario_len,
	output emu_ctrl_pkg::ctrl_phase_t phase,
	output logic                      run_active,
	output logic                      scen_boundary
);

	emu_ctrl_pkg::ctrl_phase_t phase_nxt;
	emu_cfg_pkg::scen_len_t scen_cnt;   // position within period
	logic accept;                       // sample taken this cycle
	logic last_cnt;

	////////////////////////////////////////////////////////////////////////////
	// phase sequencing
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		phase_nxt = phase;   // hold by default
		case (phase)
			emu_ctrl_pkg::phase_idle: begin
				if (boot_up) begin
					phase_nxt = emu_ctrl_pkg::phase_boot;
				end
			end
			emu_ctrl_pkg::phase_boot: begin
				// boot ends when the level drops
				if (!boot_up) begin
					phase_nxt = emu_ctrl_pkg::phase_ready;
				end
			end
			emu_ctrl_pkg::phase_ready: begin
				if (start) begin
					phase_nxt = emu_ctrl_pkg::phase_run;
				end
			end
			emu_ctrl_pkg::phase_run: begin
				phase_nxt = emu_ctrl_pkg::phase_run;   // stays until reset
			end
			default: begin
				phase_nxt = emu_ctrl_pkg::phase_idle;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			phase      <= emu_ctrl_pkg::phase_idle;
			run_active <= 1'b0;
		end else begin
			phase      <= phase_nxt;
			run_active <= (phase_nxt == emu_ctrl_pkg::phase_run);   // tracks run phase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// scenario period counter
	////////////////////////////////////////////////////////////////////////////

	assign accept   = run_active && data_valid;
	assign last_cnt = (scen_cnt == scenario_len - emu_cfg_pkg::scen_len_t'(1));

	// same-cycle pulse on the last accepted sample of a period
	assign scen_boundary = accept && last_cnt;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			scen_cnt <= '0;
		end else if (accept) begin
			if (last_cnt) begin
				scen_cnt <= '0;   // wrap into next period
			end else begin
				scen_cnt <= scen_cnt + emu_cfg_pkg::scen_len_t'(1);
			end
		end
	end

endmodule

//--- logic/delay_table.sv
`timescale 1ns/1ps

module delay_table (
	input  logic                          CLK,
	input  logic                          rst_n,
	input  emu_ctrl_pkg::ctrl_phase_t     phase,
	input  logic                          input_valid,    // boot entry strobe
	input  logic                          scen_valid,     // scenario update strobe
	input  logic                          table_update,   // commit request
	input  logic                          scen_boundary,
	input  emu_cfg_pkg::delay_t           delay_matrix_element,
	input  emu_cfg_pkg::obj_id_t          obj_id_element,
	output emu_cfg_pkg::delay_t           active_delay_0,
	output emu_cfg_pkg::delay_t           active_delay_1,
	output emu_cfg_pkg::delay_t           active_delay_2,
	output emu_cfg_pkg::delay_t           active_delay_3,
	output logic [emu_cfg_pkg::n_obj-1:0] active_loaded
);

	// tables
	emu_cfg_pkg::delay_t active_tab [emu_cfg_pkg::n_obj];   // drives the taps
	emu_cfg_pkg::delay_t shadow_tab [emu_cfg_pkg::n_obj];   // collects updates

	logic [emu_cfg_pkg::n_obj-1:0] loaded;
	logic pending;    // commit waiting for a boundary
	logic boot_wr;
	logic scen_wr;
	logic commit;

	////////////////////////////////////////////////////////////////////////////
	// write routing
	////////////////////////////////////////////////////////////////////////////

	// boot entries land in both tables
	assign boot_wr = input_valid && (phase == emu_ctrl_pkg::phase_boot);

	// scenario updates only touch the shadow copy
	assign scen_wr = scen_valid && (phase == emu_ctrl_pkg::phase_run);

	// swap only on a period edge so taps stay fixed within a period
	assign commit = scen_boundary && pending;

	always_ff @(posedge CLK) begin
		if (commit) begin
			for (int k = 0; k < emu_cfg_pkg::n_obj; k++) begin
				active_tab[k] <= shadow_tab[k];   // whole table at once
			end
		end else if (boot_wr) begin
			active_tab[obj_id_element] <= delay_matrix_element;
		end

		if (boot_wr || scen_wr) begin
			shadow_tab[obj_id_element] <= delay_matrix_element;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// loaded flags and pending commit
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			loaded  <= '0;
			pending <= 1'b0;
		end else begin
			if (boot_wr) begin
				loaded[obj_id_element] <= 1'b1;   // object now has a tap
			end

			// a fresh request wins over the clear
			if (table_update) begin
				pending <= 1'b1;
			end else if (commit) begin
				pending <= 1'b0;
			end
		end
	end

	// outputs
	assign active_delay_0 = active_tab[0];
	assign active_delay_1 = active_tab[1];
	assign active_delay_2 = active_tab[2];
	assign active_delay_3 = active_tab[3];
	assign active_loaded  = loaded;

endmodule

//--- logic/emu_ctrl_pkg.sv
package emu_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// controller phases
	////////////////////////////////////////////////////////////////////////////

	// idle until boot_up, table load during boot, then wait for start
	typedef enum logic [1:0] {
		phase_idle  = 2'd0,
		phase_boot  = 2'd1,   // delay table loading
		phase_ready = 2'd2,   // loaded, waiting on start
		phase_run   = 2'd3    // samples flowing
	} ctrl_phase_t;

	////////////////////////////////////////////////////////////////////////////
	// scenario control
	////////////////////////////////////////////////////////////////////////////

	// a tap never reads the word being written this cycle
	localparam int unsigned min_tap_offset = 1;

endpackage

//--- logic/emu_cfg_pkg.sv
package emu_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// datapath sizing
	////////////////////////////////////////////////////////////////////////////

	localparam int n_obj = 4;          // object taps per tile
	localparam int iq_width = 16;      // one rail, I or Q
	localparam int sample_width = 2 * iq_width;   // packed complex word

	// ring memory
	localparam int sample_addr_width = 8;
	localparam int ring_depth = 1 << sample_addr_width;   // 256 words

	// table and scenario widths
	localparam int delay_width = 14;   // path delay in samples
	localparam int obj_id_width = 2;   // log2 of n_obj
	localparam int scen_len_width = 13;

	////////////////////////////////////////////////////////////////////////////
	// vector types
	////////////////////////////////////////////////////////////////////////////

	// complex sample, I in the upper half, Q in the lower
	typedef logic [sample_width-1:0] sample_t;

	// ring address, wraps modulo ring_depth
	typedef logic [sample_addr_width-1:0] sample_addr_t;

	typedef logic [delay_width-1:0] delay_t;       // per-object path delay
	typedef logic [obj_id_width-1:0] obj_id_t;     // object index into tables

	// samples per scenario period
	typedef logic [scen_len_width-1:0] scen_len_t;

endpackage
